//--- hdl/rx_settings.svh
// receiver channel count, sample buffer depth and address width, sample word width
`ifndef RX_SETTINGS_SVH
`define RX_SETTINGS_SVH

//////////////////////////////////////////////////
// channel side

`define RX_CHANS	4		// receiver channels packed per sample group
`define RX_WORD_W	16		// one i, q or iq3 word, also one buffer word

//////////////////////////////////////////////////
// shared sample buffer

`define RXBUF_DEPTH	2048	// words, pointers wrap at this size
`define RXBUF_AW	11		// log2 of RXBUF_DEPTH

// a block of nsamps groups takes nsamps*RX_CHANS*3 + 4 words,
// so several blocks fit before the writer laps the reader

`endif

//--- hdl/rx_pkg.sv
// rx_pkg: buffer word, timestamp, address, channel, count types and the sequencer enums
`include "rx_settings.svh"

package rx_pkg;

	typedef logic [`RX_WORD_W-1:0]	sample_word_t;	// one buffer word
	typedef logic [47:0]			ticks_t;		// adc_clk tick timestamp
	typedef logic [`RXBUF_AW-1:0]	buf_addr_t;		// read or write pointer
	typedef logic [1:0]				chan_t;			// receiver channel index
	typedef logic [7:0]				nsamps_t;		// sample groups per block
	typedef logic [15:0]			buf_ctr_t;		// completed blocks

	// which word goes into the buffer next
	typedef enum logic [2:0] {WS_I, WS_Q, WS_IQ3, WS_T0, WS_T1, WS_T2, WS_CTR} word_sel_t;

	// packing sequencer
	typedef enum logic [2:0] {ST_IDLE, ST_CHAN, ST_GAP, ST_TICKS, ST_CTR} seq_state_t;

endpackage

//--- hdl/rx_sample_latch.sv
// rx_sample_latch: captures i, q and iq3 of every channel and registers the selected word
`timescale 1ns/1ps
`include "rx_settings.svh"

module rx_sample_latch (
	input  logic							adc_clk,
	input  logic							rx_avail_i,		// new sample group
	input  logic [`RX_CHANS*`RX_WORD_W-1:0]	rx_i_i,
	input  logic [`RX_CHANS*`RX_WORD_W-1:0]	rx_q_i,
	input  logic [`RX_CHANS*`RX_WORD_W-1:0]	rx_iq3_i,
	input  rx_pkg::chan_t					chan_i,
	input  rx_pkg::word_sel_t				word_sel_i,
	output rx_pkg::sample_word_t			word_o
);
	import rx_pkg::*;

	// snapshot of all channels, held while the sequencer walks them
	logic [`RX_CHANS*`RX_WORD_W-1:0] cap_i, cap_q, cap_iq3;

	always_ff @(posedge adc_clk)
	begin
		if (rx_avail_i)
		begin
			cap_i   <= rx_i_i;
			cap_q   <= rx_q_i;
			cap_iq3 <= rx_iq3_i;
		end
	end

	// output trails the select by one clock
	always_ff @(posedge adc_clk)
	begin
		case (word_sel_i)
			WS_I:    word_o <= cap_i[chan_i*`RX_WORD_W +: `RX_WORD_W];
			WS_Q:    word_o <= cap_q[chan_i*`RX_WORD_W +: `RX_WORD_W];
			WS_IQ3:  word_o <= cap_iq3[chan_i*`RX_WORD_W +: `RX_WORD_W];
			default: word_o <= word_o;		// trailer words come from the word source
		endcase
	end

endmodule

//--- hdl/rx_pack_seq.sv
// rx_pack_seq: nsamps register, group count and block packing FSM with write strobe
`timescale 1ns/1ps
`include "rx_settings.svh"

module rx_pack_seq (
	input  logic				adc_clk,
	input  logic				reset_bufs_A,
	input  logic				rx_avail_i,		// one group ready
	input  logic				set_nsamps_i,
	input  rx_pkg::nsamps_t		nsamps_i,
	output rx_pkg::chan_t		chan_o,			// channel being moved
	output rx_pkg::word_sel_t	word_sel_o,		// word being moved
	output logic				wr_o,			// buffer write, lined up with latch output
	output logic				blk_done_o		// one clock at end of block
);
	import rx_pkg::*;

	seq_state_t	state;
	nsamps_t	nsamps_q;	// groups per block
	nsamps_t	count;		// group within block
	logic		sel_vld;	// chan_o and word_sel_o name a word this clock
	logic		last_chan;
	logic		last_grp;

	assign last_chan = (chan_o == chan_t'(`RX_CHANS - 1));
	assign last_grp  = (count == nsamps_q - 8'd1);

	always_ff @(posedge adc_clk)
	begin
		if (set_nsamps_i)
			nsamps_q <= nsamps_i;
	end

	//////////////////////////////////////////////////
	// sequencer
	// group:   i q iq3 per channel, then wait for the next avail
	// last:    same, then t0 t1 t2 ctr with no pause, then blk_done

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			state      <= ST_IDLE;
			chan_o     <= '0;
			word_sel_o <= WS_I;
			count      <= '0;
			sel_vld    <= 1'b0;
			wr_o       <= 1'b0;
			blk_done_o <= 1'b0;
		end
		else
		begin
			wr_o       <= sel_vld;		// latch registers the word one clock later
			blk_done_o <= 1'b0;
			case (state)
				ST_IDLE, ST_GAP:
				begin
					if (rx_avail_i)		// group write starts next clock
					begin
						state      <= ST_CHAN;
						chan_o     <= '0;
						word_sel_o <= WS_I;
						sel_vld    <= 1'b1;
					end
				end
				ST_CHAN:
				begin
					case (word_sel_o)
						WS_I: word_sel_o <= WS_Q;
						WS_Q: word_sel_o <= WS_IQ3;
						default:
						begin
							if (!last_chan)
							begin
								chan_o     <= chan_o + 2'd1;
								word_sel_o <= WS_I;
							end
							else if (last_grp)		// keep going into the trailer
							begin
								state      <= ST_TICKS;
								word_sel_o <= WS_T0;
							end
							else
							begin
								state   <= ST_GAP;	// stop until next avail
								count   <= count + 8'd1;
								sel_vld <= 1'b0;
							end
						end
					endcase
				end
				ST_TICKS:
				begin
					case (word_sel_o)
						WS_T0: word_sel_o <= WS_T1;
						WS_T1: word_sel_o <= WS_T2;
						default:
						begin
							state      <= ST_CTR;
							word_sel_o <= WS_CTR;	// single counter word
						end
					endcase
				end
				ST_CTR:
				begin
					state      <= ST_IDLE;
					count      <= '0;
					sel_vld    <= 1'b0;
					blk_done_o <= 1'b1;		// same clock as the counter word write
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- hdl/rx_word_source.sv
// rx_word_source: tick latch, completed-block counter and buffer write data mux
`timescale 1ns/1ps

module rx_word_source (
	input  logic					adc_clk,
	input  logic					reset_bufs_A,
	input  logic					rx_avail_i,
	input  rx_pkg::ticks_t			ticks_i,
	input  rx_pkg::word_sel_t		word_sel_i,
	input  rx_pkg::sample_word_t	chan_word_i,	// from the sample latch
	input  logic					blk_done_i,
	output rx_pkg::sample_word_t	din_o,
	output rx_pkg::buf_ctr_t		buf_ctr_o
);
	import rx_pkg::*;

	ticks_t		ticks_q;	// timestamp of the latest group
	word_sel_t	sel_d;		// select delayed to match the latch

	always_ff @(posedge adc_clk)
	begin
		if (rx_avail_i)
			ticks_q <= ticks_i;
		sel_d <= word_sel_i;
	end

	// counter word is written before this increments
	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
			buf_ctr_o <= '0;
		else if (blk_done_i)
			buf_ctr_o <= buf_ctr_o + 16'd1;
	end

	always_comb
	begin
		case (sel_d)
			WS_T0:   din_o = ticks_q[15:0];		// low word first
			WS_T1:   din_o = ticks_q[31:16];
			WS_T2:   din_o = ticks_q[47:32];
			WS_CTR:  din_o = sample_word_t'(buf_ctr_o);
			default: din_o = chan_word_i;
		endcase
	end

endmodule

//--- hdl/rx_sample_buffer.sv
// rx_sample_buffer: dual-port sample memory, write pointer and registered read
`timescale 1ns/1ps
`include "rx_settings.svh"

module rx_sample_buffer (
	input  logic					adc_clk,
	input  logic					reset_bufs_A,
	input  logic					wr_i,
	input  rx_pkg::sample_word_t	din_i,
	input  rx_pkg::buf_addr_t		raddr_i,
	output rx_pkg::sample_word_t	dout_o
);
	import rx_pkg::*;

	sample_word_t	mem [`RXBUF_DEPTH];
	buf_addr_t		waddr;		// wraps, no check against the reader

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
			waddr <= '0;
		else if (wr_i)
			waddr <= waddr + buf_addr_t'(1);
	end

	always_ff @(posedge adc_clk)
	begin
		if (wr_i)
			mem[waddr] <= din_i;
		dout_o <= mem[raddr_i];		// read port, one clock
	end

endmodule

//--- hdl/rx_host_port.sv
// rx_host_port: read pointer, read pulse and word output, service request flags
`timescale 1ns/1ps

module rx_host_port (
	input  logic					adc_clk,
	input  logic					reset_bufs_A,
	input  logic					get_samp_i,		// host takes one word
	input  rx_pkg::sample_word_t	dout_i,
	input  logic					blk_done_i,
	input  logic					srq_query_i,
	output rx_pkg::buf_addr_t		raddr_o,
	output logic					rx_rd_o,
	output rx_pkg::sample_word_t	rx_dout_o,
	output logic					srq_o
);
	import rx_pkg::*;

	logic srq_noted;	// block finished since last query

	// buffer sees the old pointer on the get clock, word arrives next clock
	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			raddr_o <= '0;
			rx_rd_o <= 1'b0;
		end
		else
		begin
			if (get_samp_i)
				raddr_o <= raddr_o + buf_addr_t'(1);
			rx_rd_o <= get_samp_i;
		end
	end

	assign rx_dout_o = dout_i;

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			srq_noted <= 1'b0;
			srq_o     <= 1'b0;
		end
		else if (srq_query_i)
		begin
			srq_noted <= blk_done_i;	// a block ending now counts for the next query
			srq_o     <= srq_noted;
		end
		else
			srq_noted <= srq_noted | blk_done_i;
	end

endmodule

//--- hdl/rx_top.sv
// rx_top: audio sample packing top level, latch, sequencer, word source, buffer, host port
`timescale 1ns/1ps
`include "rx_settings.svh"

module rx_top (
	input  logic							adc_clk,
	input  logic							reset_bufs_A,
	input  logic							rx_avail_i,
	input  logic [`RX_CHANS*`RX_WORD_W-1:0]	rx_i_i,
	input  logic [`RX_CHANS*`RX_WORD_W-1:0]	rx_q_i,
	input  logic [`RX_CHANS*`RX_WORD_W-1:0]	rx_iq3_i,
	input  rx_pkg::ticks_t					ticks_i,
	input  logic							set_nsamps_i,
	input  rx_pkg::nsamps_t					nsamps_i,
	input  logic							get_samp_i,
	input  logic							srq_query_i,
	output logic							rx_rd_o,
	output rx_pkg::sample_word_t			rx_dout_o,
	output logic							srq_o,
	output rx_pkg::buf_ctr_t				buf_ctr_o
);
	import rx_pkg::*;

	chan_t			chan;		// sequencer selects
	word_sel_t		word_sel;
	logic			wr;
	logic			blk_done;
	sample_word_t	chan_word;	// latch output
	sample_word_t	din;		// buffer write data
	buf_addr_t		raddr;
	sample_word_t	dout;

	//////////////////////////////////////////////////
	// write side

	rx_sample_latch rx_sample_latch_inst (
		.adc_clk(adc_clk), .rx_avail_i(rx_avail_i),
		.rx_i_i(rx_i_i), .rx_q_i(rx_q_i), .rx_iq3_i(rx_iq3_i),
		.chan_i(chan), .word_sel_i(word_sel), .word_o(chan_word)
	);

	rx_pack_seq rx_pack_seq_inst (
		.adc_clk(adc_clk), .reset_bufs_A(reset_bufs_A), .rx_avail_i(rx_avail_i),
		.set_nsamps_i(set_nsamps_i), .nsamps_i(nsamps_i),
		.chan_o(chan), .word_sel_o(word_sel), .wr_o(wr), .blk_done_o(blk_done)
	);

	rx_word_source rx_word_source_inst (
		.adc_clk(adc_clk), .reset_bufs_A(reset_bufs_A), .rx_avail_i(rx_avail_i),
		.ticks_i(ticks_i), .word_sel_i(word_sel), .chan_word_i(chan_word),
		.blk_done_i(blk_done), .din_o(din), .buf_ctr_o(buf_ctr_o)
	);

	//////////////////////////////////////////////////
	// shared buffer and host read side

	rx_sample_buffer rx_sample_buffer_inst (
		.adc_clk(adc_clk), .reset_bufs_A(reset_bufs_A), .wr_i(wr),
		.din_i(din), .raddr_i(raddr), .dout_o(dout)
	);

	rx_host_port rx_host_port_inst (
		.adc_clk(adc_clk), .reset_bufs_A(reset_bufs_A), .get_samp_i(get_samp_i),
		.dout_i(dout), .blk_done_i(blk_done), .srq_query_i(srq_query_i),
		.raddr_o(raddr), .rx_rd_o(rx_rd_o), .rx_dout_o(rx_dout_o), .srq_o(srq_o)
	);

endmodule

//--- tb/tb_rx_top.sv
// rx_top testbench with clock, reset, block layout model, directed tests, checker and watchdog
`timescale 1ns/1ps
`include "rx_settings.svh"

module tb_rx_top;
	import rx_pkg::*;

	localparam int CLK_HALF_NS = 20;				// 40 ns adc_clk
	localparam int DRIVE_NS    = 2;					// inputs move this long after the edge
	localparam int GRP_WORDS   = `RX_CHANS*3;		// words per sample group
	localparam int GRP_WAIT    = GRP_WORDS + 6;		// group write plus latch and wr delay
	localparam int BLK_TIMEOUT = 100;				// clocks for a trailer to land
	// around 16 times the 12 us that the tests take
	localparam int WATCHDOG_NS = 200_000;

	logic							adc_clk;
	logic							reset_bufs_A;
	logic							rx_avail_i;
	logic [`RX_CHANS*`RX_WORD_W-1:0]	rx_i_i;
	logic [`RX_CHANS*`RX_WORD_W-1:0]	rx_q_i;
	logic [`RX_CHANS*`RX_WORD_W-1:0]	rx_iq3_i;
	ticks_t							ticks_i;
	logic							set_nsamps_i;
	nsamps_t						nsamps_i;
	logic							get_samp_i;
	logic							srq_query_i;
	logic							rx_rd_o;
	sample_word_t					rx_dout_o;
	logic							srq_o;
	buf_ctr_t						buf_ctr_o;

	int				checks;
	int				errors;
	logic [15:0]	lfsr;			// random word source
	sample_word_t	exp_q[$];		// buffer model in write order
	buf_ctr_t		exp_ctr;		// blocks completed so far

	rx_top rx_top_inst (
		.adc_clk(adc_clk), .reset_bufs_A(reset_bufs_A), .rx_avail_i(rx_avail_i),
		.rx_i_i(rx_i_i), .rx_q_i(rx_q_i), .rx_iq3_i(rx_iq3_i), .ticks_i(ticks_i),
		.set_nsamps_i(set_nsamps_i), .nsamps_i(nsamps_i), .get_samp_i(get_samp_i),
		.srq_query_i(srq_query_i), .rx_rd_o(rx_rd_o), .rx_dout_o(rx_dout_o),
		.srq_o(srq_o), .buf_ctr_o(buf_ctr_o)
	);

	initial
	begin
		adc_clk = 1'b0;
		forever #(CLK_HALF_NS) adc_clk = ~adc_clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("error: watchdog expired, tests did not finish within %0d ns", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// helpers

	// galois lfsr stepped once per bit taken
	function automatic sample_word_t rand_word();
		sample_word_t w;
		w = '0;
		for (int b = 0; b < `RX_WORD_W; b++)
		begin
			w = {w[`RX_WORD_W-2:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return w;
	endfunction

	task automatic compare(input string name, input logic [47:0] want, input logic [47:0] got);
		checks++;
		if (want !== got)
		begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", name, want, got);
		end
	endtask

	task automatic step_clk();
		@(posedge adc_clk);
		#(DRIVE_NS);		// outputs have settled by the drive point
	endtask

	task automatic pulse_reset(input int cycles);
		reset_bufs_A = 1'b1;
		repeat (cycles) step_clk();
		reset_bufs_A = 1'b0;
	endtask

	task automatic load_nsamps(input nsamps_t n);
		nsamps_i     = n;
		set_nsamps_i = 1'b1;
		step_clk();
		set_nsamps_i = 1'b0;
		nsamps_i     = ~n;		// only the registered count applies
	endtask

	// one avail strobe with fresh words pushed to the model as i q iq3 per channel
	task automatic feed_group(input bit last_grp);
		ticks_t tk;
		for (int c = 0; c < `RX_CHANS; c++)
		begin
			rx_i_i[c*`RX_WORD_W +: `RX_WORD_W]   = rand_word();
			rx_q_i[c*`RX_WORD_W +: `RX_WORD_W]   = rand_word();
			rx_iq3_i[c*`RX_WORD_W +: `RX_WORD_W] = rand_word();
			exp_q.push_back(rx_i_i[c*`RX_WORD_W +: `RX_WORD_W]);
			exp_q.push_back(rx_q_i[c*`RX_WORD_W +: `RX_WORD_W]);
			exp_q.push_back(rx_iq3_i[c*`RX_WORD_W +: `RX_WORD_W]);
		end
		tk = {rand_word(), rand_word(), rand_word()};
		ticks_i    = tk;
		rx_avail_i = 1'b1;
		step_clk();
		rx_avail_i = 1'b0;
		ticks_i    = ~tk;		// must not reach the trailer
		rx_i_i     = ~rx_i_i;	// latch must hold the captured words
		rx_q_i     = ~rx_q_i;
		rx_iq3_i   = ~rx_iq3_i;
		if (last_grp)
		begin
			exp_q.push_back(tk[15:0]);		// trailer starts with the low tick word
			exp_q.push_back(tk[31:16]);
			exp_q.push_back(tk[47:32]);
			exp_q.push_back(sample_word_t'(exp_ctr));	// counter before increment
		end
		else
			repeat (GRP_WAIT) step_clk();
	endtask

	// feed a whole block and wait for buf_ctr_o to move on
	task automatic feed_block(input int n);
		int k;
		for (int g = 0; g < n; g++)
			feed_group(g == n - 1);
		k = 0;
		while (buf_ctr_o !== exp_ctr + 16'd1 && k < BLK_TIMEOUT)
		begin
			step_clk();
			k++;
		end
		if (buf_ctr_o !== exp_ctr + 16'd1)
		begin
			errors++;
			$display("error: block %0d did not complete within %0d clocks", exp_ctr, BLK_TIMEOUT);
		end
		exp_ctr++;
	endtask

	// rx_rd_o and the word follow the get strobe by one clock
	task automatic read_words(input string name, input int count);
		sample_word_t want;
		for (int k = 0; k < count; k++)
		begin
			want = exp_q.pop_front();
			get_samp_i = 1'b1;
			step_clk();
			get_samp_i = 1'b0;
			compare($sformatf("%s rd %0d", name, k), 48'(1'b1), 48'(rx_rd_o));
			compare($sformatf("%s word %0d", name, k), 48'(want), 48'(rx_dout_o));
			step_clk();
			compare($sformatf("%s rd end %0d", name, k), 48'(1'b0), 48'(rx_rd_o));
		end
	endtask

	task automatic query_srq(input string name, input logic want);
		srq_query_i = 1'b1;
		step_clk();
		srq_query_i = 1'b0;
		compare(name, 48'(want), 48'(srq_o));
	endtask

	//////////////////////////////////////////////////
	// directed tests

	task automatic test_reset_state();
		compare("reset rx_rd_o", 48'(1'b0), 48'(rx_rd_o));
		compare("reset srq_o", 48'(1'b0), 48'(srq_o));
		compare("reset buf_ctr_o", 48'(16'd0), 48'(buf_ctr_o));
	endtask

	task automatic test_channel_words();
		load_nsamps(8'd2);
		feed_block(2);
		read_words("channel words", 2*GRP_WORDS);
	endtask

	task automatic test_trailer();
		read_words("trailer", 4);		// t0 t1 t2 ctr
		compare("trailer buf_ctr_o", 48'(16'd1), 48'(buf_ctr_o));
	endtask

	task automatic test_service_request();
		query_srq("srq after block", 1'b1);
		query_srq("srq no new block", 1'b0);
	endtask

	task automatic test_second_block();
		feed_block(2);
		read_words("second block", 2*GRP_WORDS + 4);	// counter word 1
		compare("second buf_ctr_o", 48'(16'd2), 48'(buf_ctr_o));
	endtask

	task automatic test_buffer_reset();
		feed_group(1'b0);		// block left open after group 0 of 2
		pulse_reset(1);
		exp_q.delete();
		exp_ctr = '0;
		feed_block(2);
		read_words("after reset", 2*GRP_WORDS + 4);
		compare("after reset buf_ctr_o", 48'(16'd1), 48'(buf_ctr_o));
	endtask

	initial
	begin
		reset_bufs_A = 1'b1;
		rx_avail_i   = 1'b0;
		rx_i_i       = '0;
		rx_q_i       = '0;
		rx_iq3_i     = '0;
		ticks_i      = '0;
		set_nsamps_i = 1'b0;
		nsamps_i     = '0;
		get_samp_i   = 1'b0;
		srq_query_i  = 1'b0;
		lfsr         = 16'd43;
		checks       = 0;
		errors       = 0;
		exp_ctr      = '0;
		pulse_reset(5);
		test_reset_state();
		test_channel_words();
		test_trailer();
		test_service_request();
		test_second_block();
		test_buffer_reset();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- list.f
+incdir+hdl
hdl/rx_pkg.sv
hdl/rx_sample_latch.sv
hdl/rx_pack_seq.sv
hdl/rx_word_source.sv
hdl/rx_sample_buffer.sv
hdl/rx_host_port.sv
hdl/rx_top.sv
tb/tb_rx_top.sv

//--- Makefile
# Verilator build for the rx_top sample packing design and its testbench

VERILATOR ?= verilator
TOP       ?= tb_rx_top
RTL_TOP   ?= rx_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
